/* bench/div_clk_gen.sv */
`timescale 1ns/1ps

module div_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // half a period high, half a period low.
  always begin
    #(PERIOD_NS / 2);
    o_clk = ~o_clk;
  end

endmodule

/* bench/div_unit_tb.sv */
`timescale 1ns/1ps

module div_unit_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_DIRECTED = 31;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;

  logic               i_clk;
  logic               i_rst_n;
  logic               i_flush;
  logic               i_start;
  div_pkg::div_req_t  i_req;
  logic               o_busy;
  logic               o_resp_valid;
  logic               i_resp_ready;
  div_pkg::div_resp_t o_resp;
  int                 seed = 30;

  div_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_div_clk_gen (.o_clk(i_clk));

  div_unit #(.WIDTH(64)) u_div_unit (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_flush      (i_flush),
    .i_start      (i_start),
    .i_req        (i_req),
    .o_busy       (o_busy),
    .o_resp_valid (o_resp_valid),
    .i_resp_ready (i_resp_ready),
    .o_resp       (o_resp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic is_word_op(input div_pkg::div_op_e op);
    return op inside {div_pkg::DIVW, div_pkg::DIVUW, div_pkg::REMW, div_pkg::REMUW};
  endfunction

  function automatic div_pkg::div_resp_t model_div(input div_pkg::div_op_e op,
                                                   input logic [63:0] a,
                                                   input logic [63:0] b);
    logic               word_op;
    logic               rem_op;
    logic               signed_op;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        q;
    logic [63:0]        r;
    div_pkg::div_resp_t resp;
    word_op   = is_word_op(op);
    rem_op    = op inside {div_pkg::REM, div_pkg::REMU, div_pkg::REMW, div_pkg::REMUW};
    signed_op = op inside {div_pkg::DIV, div_pkg::REM, div_pkg::DIVW, div_pkg::REMW};
    if (word_op) begin // only the low word counts, extended the way the opcode reads it.
      sa = signed_op ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
      sb = signed_op ? {{32{b[31]}}, b[31:0]} : {32'd0, b[31:0]};
    end else begin
      sa = a;
      sb = b;
    end
    ua = sa;
    ub = sb;
    resp.special = div_pkg::SPC_NONE;
    if (ub == 64'd0) begin
      q = '1;
      r = ua;
      resp.special = div_pkg::SPC_DIV_ZERO;
    end else if (signed_op && ub == '1 &&
                 ua == (word_op ? {{33{1'b1}}, 31'd0} : {1'b1, 63'd0})) begin
      q = ua; // most negative over minus one wraps to itself.
      r = '0;
      resp.special = div_pkg::SPC_OVERFLOW;
    end else if (signed_op) begin
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = ua / ub;
      r = ua % ub;
    end
    resp.result = rem_op ? r : q;
    if (word_op) begin
      resp.result = {{32{resp.result[31]}}, resp.result[31:0]};
    end
    return resp;
  endfunction

  function automatic int expected_latency(input div_pkg::div_op_e op,
                                          input div_pkg::div_special_e special);
    if (special != div_pkg::SPC_NONE) begin
      return 2;
    end else if (is_word_op(op)) begin
      return 34; // 32 steps plus launch and response.
    end
    return 66;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "div_unit_tb: run stopped at the first error.");
  endtask

  task automatic check_resp(input string name, input div_pkg::div_resp_t exp,
                            input div_pkg::div_resp_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: expected %h %s, actual %h %s", name, exp.result,
                               exp.special.name(), act.result, act.special.name()));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      report_failure($sformatf("Fail %s latency: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus handling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // every task is entered 1 ns after a rising edge and returns at the same point.
  task automatic launch(input div_pkg::div_op_e op, input logic [63:0] a,
                        input logic [63:0] b);
    i_req.op       = op;
    i_req.dividend = a;
    i_req.divisor  = b;
    i_start        = 1'b1;
    @(posedge i_clk); // this edge is cycle 0.
    #1;
    i_start = 1'b0;
  endtask

  task automatic wait_resp(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
      if (cycles > 100) begin
        report_failure($sformatf("%s: no response arrived within 100 cycles.", name));
      end
    end while (!o_resp_valid);
  endtask

  task automatic take_resp(input string name);
    @(posedge i_clk);
    #1;
    check_flag({name, " valid after transfer"}, 1'b0, o_resp_valid);
    check_flag({name, " busy after transfer"}, 1'b0, o_busy);
  endtask

  task automatic run_op(input string name, input div_pkg::div_op_e op,
                        input logic [63:0] a, input logic [63:0] b);
    div_pkg::div_resp_t exp;
    int                 cycles;
    exp = model_div(op, a, b);
    launch(op, a, b);
    wait_resp(name, cycles);
    check_latency(name, expected_latency(op, exp.special), cycles);
    check_resp(name, exp, o_resp);
    take_resp(name);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_unsigned();
    run_op("divu large", div_pkg::DIVU, 64'hffff_ffff_ffff_fffe, 64'd7);
    run_op("remu large", div_pkg::REMU, 64'hffff_ffff_ffff_fffe, 64'd7);
    run_op("divu below divisor", div_pkg::DIVU, 64'd5, 64'h8000_0000_0000_0000);
    run_op("remu wide divisor", div_pkg::REMU, 64'h1234_5678_9abc_def0, 64'h1_0000_0003);
  endtask

  task automatic test_signed();
    logic [63:0] a;
    logic [63:0] b;
    for (int i = 0; i < 4; i++) begin
      a = i[0] ? -64'sd1000003 : 64'sd1000003; // every sign pairing once.
      b = i[1] ? -64'sd17 : 64'sd17;
      run_op($sformatf("div signs %0d", i), div_pkg::DIV, a, b);
      run_op($sformatf("rem signs %0d", i), div_pkg::REM, a, b);
    end
    run_op("div near minimum", div_pkg::DIV, 64'h8000_0000_0000_0001, 64'd3);
  endtask

  task automatic test_word();
    run_op("divw", div_pkg::DIVW, 64'hdead_beef_ffff_fff9, 64'h1234_5678_0000_0002);
    run_op("divuw", div_pkg::DIVUW, 64'h0000_0001_ffff_fff0, 64'hffff_0000_0000_0010);
    run_op("divuw high bit", div_pkg::DIVUW, 64'h5555_5555_ffff_fff0, 64'h7777_7777_0000_0001);
    run_op("remw", div_pkg::REMW, 64'hdead_beef_ffff_fff9, 64'h1234_5678_0000_0002);
    run_op("remuw", div_pkg::REMUW, 64'h0000_0000_ffff_fff1, 64'h0000_0001_0000_0010);
  endtask

  task automatic test_special();
    run_op("div by zero", div_pkg::DIV, 64'h0000_0000_0000_1234, 64'd0);
    run_op("rem by zero", div_pkg::REM, 64'hf000_0000_0000_1234, 64'd0);
    run_op("divu by zero", div_pkg::DIVU, 64'h0000_0000_0000_1234, 64'd0);
    run_op("remu by zero", div_pkg::REMU, 64'h8765_4321_0000_0001, 64'd0);
    run_op("divw by zero", div_pkg::DIVW, 64'd42, 64'hffff_ffff_0000_0000);
    run_op("remuw by zero", div_pkg::REMUW, 64'h0000_0000_8000_0001, 64'h1_0000_0000);
    run_op("div overflow", div_pkg::DIV, 64'h8000_0000_0000_0000, '1);
    run_op("rem overflow", div_pkg::REM, 64'h8000_0000_0000_0000, '1);
    run_op("divw overflow", div_pkg::DIVW, 64'h1111_1111_8000_0000, 64'h0000_0000_ffff_ffff);
    run_op("remw overflow", div_pkg::REMW, 64'h1111_1111_8000_0000, 64'h0000_0000_ffff_ffff);
  endtask

  task automatic test_backpressure();
    div_pkg::div_resp_t exp;
    int                 cycles;
    exp = model_div(div_pkg::REMW, 64'd1000, 64'd7);
    i_resp_ready = 1'b0;
    launch(div_pkg::REMW, 64'd1000, 64'd7);
    wait_resp("backpressure", cycles);
    check_latency("backpressure", expected_latency(div_pkg::REMW, exp.special), cycles);
    repeat (10) begin
      check_flag("backpressure valid", 1'b1, o_resp_valid);
      check_flag("backpressure busy", 1'b1, o_busy);
      check_resp("backpressure hold", exp, o_resp);
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
    i_resp_ready = 1'b1;
    take_resp("backpressure");
  endtask

  task automatic test_flush();
    launch(div_pkg::DIV, 64'h7fff_0000_1234_5678, 64'd3);
    repeat (20) @(posedge i_clk);
    #1;
    check_flag("busy before flush", 1'b1, o_busy);
    i_flush = 1'b1;
    @(posedge i_clk);
    #1;
    i_flush = 1'b0;
    check_flag("busy after flush", 1'b0, o_busy);
    repeat (80) begin // a dropped division must never answer.
      @(negedge i_clk);
      check_flag("no response after flush", 1'b0, o_resp_valid);
    end
    @(posedge i_clk);
    #1;
    run_op("div after flush", div_pkg::DIV, -64'sd99, 64'sd4);
  endtask

  task automatic test_random();
    logic [2:0]  op_bits;
    logic [2:0]  shape;
    logic [63:0] a;
    logic [63:0] b;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      op_bits = 3'($random(seed));
      shape   = 3'($random(seed));
      a       = {$random(seed), $random(seed)};
      b       = {$random(seed), $random(seed)};
      case (shape) // small and zero divisors show up now and then.
        3'd0:    b = '0;
        3'd1:    b = b >> 48;
        3'd2:    b = b >> 20;
        default: b = b;
      endcase
      run_op($sformatf("random %0d", n), div_pkg::div_op_e'(op_bits), a, b);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    i_rst_n      = 1'b0;
    i_flush      = 1'b0;
    i_start      = 1'b0;
    i_req        = '0;
    i_resp_ready = 1'b1;
    repeat (16) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    test_unsigned();
    test_signed();
    test_word();
    test_special();
    test_backpressure();
    test_flush();
    test_random();
    $display("TEST OK");
    $finish;
  end

  // about 70 cycles per operation is more than the longest division needs.
  initial begin
    repeat (NUM_OPS * 70 + 200) @(posedge i_clk);
    report_failure("watchdog: the run did not finish in the expected time.");
  end

endmodule

/* hw/div_ctrl.sv */
`timescale 1ns/1ps

module div_ctrl (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_flush,
  input  logic               i_start,
  input  div_pkg::div_req_t  i_req,
  input  logic               i_done,
  output logic               o_busy,
  output logic               o_core_start,
  output logic [63:0]        o_core_dividend,
  output logic [63:0]        o_core_divisor,
  output logic               o_core_signed,
  output logic               o_core_word,
  output logic               o_bypass,
  output div_pkg::div_info_t o_info
);

  logic                  accept;
  logic                  want_rem;
  logic                  is_word;
  logic                  is_signed;
  logic                  div_zero;
  logic                  overflow;
  div_pkg::div_special_e special;
  div_pkg::div_info_t    info_d;

  assign accept = i_start & ~o_busy & ~i_flush; // flush wins over a new request.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcode decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    want_rem  = 1'b0;
    is_word   = 1'b0;
    is_signed = 1'b0;
    unique case (i_req.op)
      div_pkg::DIV:   is_signed = 1'b1;
      div_pkg::DIVU:  is_signed = 1'b0;
      div_pkg::REM: begin
        want_rem  = 1'b1;
        is_signed = 1'b1;
      end
      div_pkg::REMU:  want_rem = 1'b1;
      div_pkg::DIVW: begin
        is_word   = 1'b1;
        is_signed = 1'b1;
      end
      div_pkg::DIVUW: is_word = 1'b1;
      div_pkg::REMW: begin
        want_rem  = 1'b1;
        is_word   = 1'b1;
        is_signed = 1'b1;
      end
      default: begin // REMU word form.
        want_rem = 1'b1;
        is_word  = 1'b1;
      end
    endcase
  end

  // Both special cases are judged at the width of the operation.
  always_comb begin
    if (is_word) begin
      div_zero = (i_req.divisor[31:0] == 32'd0);
      overflow = is_signed && (i_req.dividend[31:0] == 32'h8000_0000)
                 && (i_req.divisor[31:0] == 32'hffff_ffff);
    end else begin
      div_zero = (i_req.divisor == 64'd0);
      overflow = is_signed && (i_req.dividend == 64'h8000_0000_0000_0000)
                 && (i_req.divisor == 64'hffff_ffff_ffff_ffff);
    end
  end

  assign special = div_zero ? div_pkg::SPC_DIV_ZERO :
                   overflow ? div_pkg::SPC_OVERFLOW : div_pkg::SPC_NONE;

  always_comb begin
    info_d.want_rem  = want_rem;
    info_d.is_word   = is_word;
    info_d.is_signed = is_signed;
    info_d.special   = special;
    info_d.dividend  = i_req.dividend;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // launch and busy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_busy       <= 1'b0;
      o_core_start <= 1'b0;
      o_bypass     <= 1'b0;
    end else if (i_flush) begin
      o_busy       <= 1'b0;
      o_core_start <= 1'b0;
      o_bypass     <= 1'b0;
    end else begin
      o_core_start <= accept & (special == div_pkg::SPC_NONE);
      o_bypass     <= accept & (special != div_pkg::SPC_NONE);
      if (accept) begin
        o_busy <= 1'b1;
      end else if (i_done) begin
        o_busy <= 1'b0; // response has left the unit.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_info          <= info_d;
      o_core_dividend <= i_req.dividend;
      o_core_divisor  <= i_req.divisor;
      o_core_signed   <= is_signed;
      o_core_word     <= is_word;
    end
  end

  a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> !o_busy)
    else $error("div_ctrl: start issued while busy.");

  a_one_path: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_core_start && o_bypass))
    else $error("div_ctrl: core start and bypass in the same cycle.");

endmodule

/* hw/div_iter.sv */
`timescale 1ns/1ps

module div_iter #(
  parameter int WIDTH = 64
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_flush,
  input  logic             i_start,
  input  logic             i_word,
  input  logic             i_signed,
  input  logic [WIDTH-1:0] i_dividend,
  input  logic [WIDTH-1:0] i_divisor,
  output logic             o_end_valid,
  input  logic             i_end_ready,
  output logic [WIDTH-1:0] o_quotient,
  output logic [WIDTH-1:0] o_remainder
);

  localparam int CNT_W = $clog2(WIDTH);
  localparam int HALF  = WIDTH / 2;

  logic [CNT_W-1:0] cnt;
  logic             cnt_run;

  logic [WIDTH-1:0] dvd_ext;
  logic [WIDTH-1:0] dsr_ext;
  logic             dvd_neg;
  logic             dsr_neg;
  logic [WIDTH-1:0] dvd_abs;
  logic [WIDTH-1:0] dsr_abs;

  logic             word_r;
  logic             dvd_neg_r;
  logic             dsr_neg_r;
  logic [WIDTH-1:0] rem_r;  // partial remainder.
  logic [WIDTH-1:0] dvd_r;  // dividend magnitude, consumed from the top.
  logic [WIDTH-1:0] dsr_r;
  logic [WIDTH-1:0] quo_r;

  logic [WIDTH:0]   trial;
  logic [WIDTH-1:0] rem_nxt;
  logic [WIDTH-1:0] quo_nxt;
  logic [WIDTH-1:0] dvd_nxt;
  logic [WIDTH-1:0] quo_fix;
  logic [WIDTH-1:0] rem_fix;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // step counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Registered steps run while cnt is nonzero. The final step is the
  // combinational one seen at the outputs once cnt has reached zero.
  assign cnt_run = |cnt;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (i_flush) begin
      cnt <= '0;
    end else if (i_start) begin
      cnt <= i_word ? CNT_W'(HALF - 1) : CNT_W'(WIDTH - 1);
    end else if (cnt_run) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_end_valid <= 1'b0;
    end else if (i_flush) begin
      o_end_valid <= 1'b0;
    end else if (cnt == CNT_W'(1)) begin
      o_end_valid <= 1'b1;
    end else if (i_end_ready) begin
      o_end_valid <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand magnitudes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Word operands are extended from the low half. Unsigned word forms get zeros.
  always_comb begin
    if (i_word) begin
      dvd_ext = {{HALF{i_signed & i_dividend[HALF-1]}}, i_dividend[HALF-1:0]};
      dsr_ext = {{HALF{i_signed & i_divisor[HALF-1]}}, i_divisor[HALF-1:0]};
    end else begin
      dvd_ext = i_dividend;
      dsr_ext = i_divisor;
    end
  end

  assign dvd_neg = i_signed & dvd_ext[WIDTH-1];
  assign dsr_neg = i_signed & dsr_ext[WIDTH-1];
  assign dvd_abs = dvd_neg ? -dvd_ext : dvd_ext;
  assign dsr_abs = dsr_neg ? -dsr_ext : dsr_ext;

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      word_r    <= i_word;
      dvd_neg_r <= dvd_neg;
      dsr_neg_r <= dsr_neg;
      dsr_r     <= dsr_abs;
      dvd_r     <= i_word ? (dvd_abs << HALF) : dvd_abs; // word bits start at the top.
      rem_r     <= '0;
      quo_r     <= '0;
    end else if (cnt_run) begin
      rem_r <= rem_nxt;
      quo_r <= quo_nxt;
      dvd_r <= dvd_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // restoring step
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The remainder stays below the divisor, so the top bit of trial is the borrow.
  assign trial   = {rem_r, dvd_r[WIDTH-1]} - {1'b0, dsr_r};
  assign rem_nxt = trial[WIDTH] ? {rem_r[WIDTH-2:0], dvd_r[WIDTH-1]} : trial[WIDTH-1:0];
  assign quo_nxt = {quo_r[WIDTH-2:0], ~trial[WIDTH]};
  assign dvd_nxt = {dvd_r[WIDTH-2:0], 1'b0};

  // Truncating division. The remainder follows the dividend's sign.
  assign quo_fix = (dvd_neg_r ^ dsr_neg_r) ? -quo_nxt : quo_nxt;
  assign rem_fix = dvd_neg_r ? -rem_nxt : rem_nxt;

  assign o_quotient  = word_r ? {{HALF{quo_fix[HALF-1]}}, quo_fix[HALF-1:0]} : quo_fix;
  assign o_remainder = word_r ? {{HALF{rem_fix[HALF-1]}}, rem_fix[HALF-1:0]} : rem_fix;

  a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> !cnt_run && !o_end_valid)
    else $error("div_iter: start while a division is running.");

endmodule

/* hw/div_pkg.sv */
package div_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes and operation kinds
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the three bits read as {word, rem, unsigned}.
  typedef enum logic [2:0] {
    DIV   = 3'd0,
    DIVU  = 3'd1,
    REM   = 3'd2,
    REMU  = 3'd3,
    DIVW  = 3'd4,
    DIVUW = 3'd5,
    REMW  = 3'd6,
    REMUW = 3'd7
  } div_op_e;

  typedef enum logic [1:0] {
    SPC_NONE     = 2'd0, // ordinary long division.
    SPC_DIV_ZERO = 2'd1, // divisor is zero at the operation width.
    SPC_OVERFLOW = 2'd2  // most negative value divided by minus one.
  } div_special_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request, operation and response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    div_op_e     op;
    logic [63:0] dividend;
    logic [63:0] divisor;
  } div_req_t;

  // Describes the accepted operation until its response is taken.
  typedef struct packed {
    logic         want_rem;  // remainder instead of quotient.
    logic         is_word;   // 32-bit word form.
    logic         is_signed;
    div_special_e special;
    logic [63:0]  dividend;  // raw operand, source of the special results.
  } div_info_t;

  typedef struct packed {
    logic [63:0]  result;
    div_special_e special;   // lets the pipeline log the exception.
  } div_resp_t;

endpackage

/* hw/div_result.sv */
`timescale 1ns/1ps

module div_result #(
  parameter int WIDTH = 64
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_flush,
  input  div_pkg::div_info_t i_info,
  input  logic               i_bypass,
  input  logic               i_end_valid,
  output logic               o_end_ready,
  input  logic [WIDTH-1:0]   i_quotient,
  input  logic [WIDTH-1:0]   i_remainder,
  output logic               o_resp_valid,
  input  logic               i_resp_ready,
  output div_pkg::div_resp_t o_resp,
  output logic               o_done
);

  localparam int HALF = WIDTH / 2;

  logic               load;
  logic [WIDTH-1:0]   spc_quo;
  logic [WIDTH-1:0]   spc_rem;
  logic [WIDTH-1:0]   res_raw;
  logic [WIDTH-1:0]   res_d;
  div_pkg::div_resp_t resp_d;

  function automatic logic [WIDTH-1:0] sext_half(input logic [WIDTH-1:0] v);
    return {{HALF{v[HALF-1]}}, v[HALF-1:0]};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result forming
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    unique case (i_info.special)
      div_pkg::SPC_DIV_ZERO: begin
        spc_quo = '1;              // all ones.
        spc_rem = i_info.dividend;
      end
      div_pkg::SPC_OVERFLOW: begin
        spc_quo = i_info.dividend; // the quotient wraps back to the dividend.
        spc_rem = '0;
      end
      default: begin
        spc_quo = '0;
        spc_rem = '0;
      end
    endcase
  end

  always_comb begin
    if (i_bypass) begin
      res_raw = i_info.want_rem ? spc_rem : spc_quo;
    end else begin
      res_raw = i_info.want_rem ? i_remainder : i_quotient;
    end
    res_d = i_info.is_word ? sext_half(res_raw) : res_raw;
  end

  always_comb begin
    resp_d.result  = res_d;
    resp_d.special = i_info.special;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_end_ready = ~o_resp_valid; // one operation in flight, so an empty slot is enough.
  assign load        = ~o_resp_valid & (i_bypass | i_end_valid);
  assign o_done      = o_resp_valid & i_resp_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_resp_valid <= 1'b0;
    end else if (i_flush) begin
      o_resp_valid <= 1'b0;
    end else if (load) begin
      o_resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
      o_resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      o_resp <= resp_d;
    end
  end

  a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n || i_flush)
    o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp))
    else $error("div_result: response changed under back-pressure.");

endmodule

/* hw/div_unit.sv */
`timescale 1ns/1ps

module div_unit #(
  parameter int WIDTH = 64
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_flush,
  input  logic               i_start,
  input  div_pkg::div_req_t  i_req,
  output logic               o_busy,
  output logic               o_resp_valid,
  input  logic               i_resp_ready,
  output div_pkg::div_resp_t o_resp
);

  logic               core_start;
  logic [WIDTH-1:0]   core_dividend;
  logic [WIDTH-1:0]   core_divisor;
  logic               core_signed;
  logic               core_word;
  logic               bypass;
  div_pkg::div_info_t info;
  logic               end_valid;
  logic               end_ready;
  logic [WIDTH-1:0]   quotient;
  logic [WIDTH-1:0]   remainder;
  logic               done;

  // the package structs carry 64-bit operands and results.
  initial begin
    assert (WIDTH == 64) else $fatal(1, "div_unit: WIDTH must be 64.");
  end

  div_ctrl u_div_ctrl (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_flush         (i_flush),
    .i_start         (i_start),
    .i_req           (i_req),
    .i_done          (done),
    .o_busy          (o_busy),
    .o_core_start    (core_start),
    .o_core_dividend (core_dividend),
    .o_core_divisor  (core_divisor),
    .o_core_signed   (core_signed),
    .o_core_word     (core_word),
    .o_bypass        (bypass),
    .o_info          (info)
  );

  div_iter #(.WIDTH(WIDTH)) u_div_iter (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_flush),
    .i_start     (core_start),
    .i_word      (core_word),
    .i_signed    (core_signed),
    .i_dividend  (core_dividend),
    .i_divisor   (core_divisor),
    .o_end_valid (end_valid),
    .i_end_ready (end_ready),
    .o_quotient  (quotient),
    .o_remainder (remainder)
  );

  div_result #(.WIDTH(WIDTH)) u_div_result (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_flush      (i_flush),
    .i_info       (info),
    .i_bypass     (bypass),
    .i_end_valid  (end_valid),
    .o_end_ready  (end_ready),
    .i_quotient   (quotient),
    .i_remainder  (remainder),
    .o_resp_valid (o_resp_valid),
    .i_resp_ready (i_resp_ready),
    .o_resp       (o_resp),
    .o_done       (done)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 --top-module div_unit_tb \
  -f verilog.f -o div_unit_sim > build.log 2>&1 \
  && ./obj_dir/div_unit_sim > "$LOG" 2>&1 \
  || echo "build or simulation ended with an error."

grep -q "TEST OK" "$LOG" 2>/dev/null \
  && echo "simulation passed." \
  || { echo "simulation failed, see $LOG and build.log."; exit 1; }

exit 0

/* verilog.f */
hw/div_pkg.sv
hw/div_ctrl.sv
hw/div_iter.sv
hw/div_result.sv
hw/div_unit.sv
bench/div_clk_gen.sv
bench/div_unit_tb.sv
